// ==== src/alu_op_pkg.sv ====
/*
 * Word width and opcode encoding shared by the ALU datapath.
 * Opcode values keep the historic numbering so existing programs still decode.
 */

package alu_op_pkg;

	// ******************************************************************
	// Word format
	// ******************************************************************

	localparam int word_w = 32;              // Operand and result width

	typedef logic [word_w-1:0] word_t;       // One integer or float word

	// ******************************************************************
	// Opcodes
	// ******************************************************************

	// Gaps in the numbering belong to retired operations
	typedef enum logic [5:0] {
		NOP   = 6'd0,   // Pass in2
		LOD   = 6'd1,   // Pass in1
		ADD   = 6'd2,   // Integer sum
		MLT   = 6'd4,   // Low word of integer product
		F_MLT = 6'd5,   // Float multiply, normalized
		NEG   = 6'd11,  // Two's complement of in2
		F_NEG = 6'd13,  // Flip float sign of in2
		ABS   = 6'd15,  // Integer magnitude of in2
		F_ABS = 6'd17,  // Clear float sign of in2
		AND   = 6'd29,  // Bitwise and
		ORR   = 6'd30,  // Bitwise or
		XOR   = 6'd31,  // Bitwise xor
		LES   = 6'd38,  // Signed in1 < in2
		GRE   = 6'd40,  // Signed in1 > in2
		EQU   = 6'd42,  // in1 == in2
		SHL   = 6'd43,  // Logical left shift
		SHR   = 6'd44,  // Logical right shift
		SRS   = 6'd45   // Arithmetic right shift
	} alu_op_e;

endpackage

// ==== src/float_fmt_pkg.sv ====
/*
 * Field layout of the ALU float word.
 * Sign, two's-complement exponent, mantissa without hidden bit.
 */

package float_fmt_pkg;

	localparam int man_w = 23;   // Mantissa bits
	localparam int exp_w = 8;    // Exponent bits, signed

	// Normalized when man[man_w-1] is set
	typedef struct packed {
		logic             sign;  // 1 means negative
		logic [exp_w-1:0] exp;   // Two's complement
		logic [man_w-1:0] man;   // Plain magnitude
	} float_t;

	// Most negative exponent
	// Marks a zero value after normalization
	localparam logic [exp_w-1:0] exp_min = {1'b1, {(exp_w-1){1'b0}}};

endpackage

// ==== src/alu_issue_if.sv ====
/*
 * Issue bus from the request controller to both units and the result stage.
 * issue pulses once per request; op, a and b hold until the next pulse.
 */

`timescale 1ns/1ps

interface alu_issue_if;

	import alu_op_pkg::*;

	logic    issue;  // One-cycle start strobe
	alu_op_e op;     // Captured opcode
	word_t   a;      // Copy of in1
	word_t   b;      // Copy of in2

	// Controller side
	modport ctrl (output issue, output op, output a, output b);

	// Datapath side, read only
	modport unit (input issue, input op, input a, input b);

endinterface

// ==== src/alu_req_ctrl.sv ====
/*
 * Four-phase req/ack front end of the ALU.
 * Captures one operation per request and holds ack until req drops.
 */

`timescale 1ns/1ps

module alu_req_ctrl (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               req,           // Host request, four-phase
	input  alu_op_pkg::alu_op_e op,           // Held by host while req high
	input  alu_op_pkg::word_t  in1,
	input  alu_op_pkg::word_t  in2,
	input  logic               result_valid,  // Pulse from result stage
	output logic               ack,
	alu_issue_if.ctrl          iss
);

	typedef enum logic [1:0] {
		idle = 2'd0,   // Waiting for req
		busy = 2'd1,   // Operation in flight
		done = 2'd2    // ack high, waiting for req low
	} req_state_e;

	req_state_e state;

	logic accept;  // Request taken this cycle

	assign accept = (state == idle) && req;

	// ******************************************************************
	// Request FSM
	// ******************************************************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= idle;
			iss.issue <= 1'b0;
		end else begin
			iss.issue <= accept;  // Single-cycle strobe
			case (state)
				idle: if (req) state <= busy;
				busy: if (result_valid) state <= done;  // ack next cycle
				done: if (!req) state <= idle;          // Host released req
				default: state <= idle;
			endcase
		end
	end

	// Operand capture
	// Held stable until the next accepted request
	always_ff @(posedge clk) begin
		if (accept) begin
			iss.op <= op;
			iss.a  <= in1;
			iss.b  <= in2;
		end
	end

	// ack straight from the state register
	// Rises three edges after accept, falls on req low
	assign ack = (state == done);

endmodule

// ==== src/int_unit.sv ====
/*
 * Integer, bitwise, compare and shift half of the ALU.
 * Registers its result one cycle after issue; unhandled opcodes give zero.
 */

`timescale 1ns/1ps

module int_unit (
	input  logic              clk,
	input  logic              rst_n,
	alu_issue_if.unit         iss,
	output alu_op_pkg::word_t int_result
);

	import alu_op_pkg::*;

	word_t next_result;  // Combinational pick for the current opcode

	// ******************************************************************
	// Operation decode
	// ******************************************************************

	always_comb begin
		case (iss.op)
			NOP: next_result = iss.b;                          // Pass in2
			LOD: next_result = iss.a;                          // Pass in1
			ADD: next_result = iss.a + iss.b;
			MLT: next_result = iss.a * iss.b;                  // Low word only
			NEG: next_result = -iss.b;
			ABS: next_result = iss.b[word_w-1] ? -iss.b : iss.b;
			AND: next_result = iss.a & iss.b;
			ORR: next_result = iss.a | iss.b;
			XOR: next_result = iss.a ^ iss.b;
			LES: next_result = word_t'($signed(iss.a) < $signed(iss.b));
			GRE: next_result = word_t'($signed(iss.a) > $signed(iss.b));
			EQU: next_result = word_t'(iss.a == iss.b);
			SHL: next_result = iss.a << iss.b;                 // Amount unsigned
			SHR: next_result = iss.a >> iss.b;
			SRS: next_result = word_t'($signed(iss.a) >>> iss.b);  // Sign fill
			default: next_result = '0;                         // Float ops, unknown codes
		endcase
	end

	// ******************************************************************
	// Output register
	// ******************************************************************

	always_ff @(posedge clk) begin
		if (!rst_n)
			int_result <= '0;
		else if (iss.issue)
			int_result <= next_result;  // Edge after issue
	end

endmodule

// ==== src/float_unit.sv ====
/*
 * Float half of the ALU with multiply and underflow flush, negate and magnitude.
 * The multiply result leaves unnormalized for the result stage to fix.
 */

`timescale 1ns/1ps

module float_unit (
	input  logic                  clk,
	input  logic                  rst_n,
	alu_issue_if.unit             iss,
	output float_fmt_pkg::float_t float_result
);

	import alu_op_pkg::*;
	import float_fmt_pkg::*;

	float_t fa;                          // in1 viewed as float
	float_t fb;                          // in2 viewed as float
	float_t next_result;

	logic signed [exp_w:0] exp_sum;      // One guard bit for range check
	logic [2*man_w-1:0]    man_prod;     // Full mantissa product
	logic                  underflow;

	assign fa = iss.a;
	assign fb = iss.b;

	// ******************************************************************
	// Multiply datapath
	// ******************************************************************

	// Sign-extended exponents plus man_w
	// Product keeps its upper half, so scale moves by man_w
	assign exp_sum = {fa.exp[exp_w-1], fa.exp} + {fb.exp[exp_w-1], fb.exp}
		+ (exp_w+1)'(man_w);
	assign man_prod  = (2*man_w)'(fa.man) * (2*man_w)'(fb.man);
	assign underflow = (exp_sum[exp_w -: 2] == 2'b10);  // Below exponent range

	always_comb begin
		next_result = '0;
		case (iss.op)
			F_MLT: begin
				next_result.sign = fa.sign ^ fb.sign;
				next_result.exp  = exp_sum[exp_w-1:0];  // Wraps as the format does
				next_result.man  = underflow ? '0 : man_prod[2*man_w-1 -: man_w];
			end
			F_NEG: begin
				next_result      = fb;
				next_result.sign = ~fb.sign;  // Magnitude untouched
			end
			F_ABS: begin
				next_result      = fb;
				next_result.sign = 1'b0;
			end
			default: next_result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			float_result <= '0;
		else if (iss.issue)
			float_result <= next_result;  // Same edge as int_unit
	end

endmodule

// ==== src/float_normalizer.sv ====
/*
 * Combinational float normalization.
 * Shifts the mantissa up to its leading one and lowers the exponent to match.
 */

`timescale 1ns/1ps

module float_normalizer (
	input  float_fmt_pkg::float_t value,
	output float_fmt_pkg::float_t normalized
);

	import float_fmt_pkg::*;

	logic [$clog2(man_w+1)-1:0] lz;   // Leading zeros up to man_w
	logic                       found;
	logic                       man_zero;

	// ******************************************************************
	// Leading-one search
	// ******************************************************************

	// Scan from the top bit down
	// Count stops at the first one
	always_comb begin
		lz    = '0;
		found = 1'b0;
		for (int i = man_w-1; i >= 0; i--) begin
			if (value.man[i])
				found = 1'b1;
			else if (!found)
				lz++;
		end
	end

	assign man_zero = !found;  // No one bit anywhere

	// ******************************************************************
	// Shift and exponent fix
	// ******************************************************************

	always_comb begin
		normalized.sign = value.sign;  // Sign never changes
		if (man_zero) begin
			normalized.exp = exp_min;    // Canonical zero
			normalized.man = '0;
		end else begin
			normalized.exp = value.exp - exp_w'(lz);
			normalized.man = value.man << lz;
		end
	end

endmodule

// ==== src/result_select.sv ====
/*
 * Final ALU stage: picks the integer or float result and registers it.
 * Aligns issue and opcode with the unit registers and normalizes F_MLT.
 */

`timescale 1ns/1ps

module result_select (
	input  logic                  clk,
	input  logic                  rst_n,
	input  alu_op_pkg::word_t     int_result,
	input  float_fmt_pkg::float_t float_result,
	alu_issue_if.unit             iss,
	output alu_op_pkg::word_t     result,
	output logic                  result_valid  // One-cycle pulse
);

	import alu_op_pkg::*;
	import float_fmt_pkg::*;

	logic    issue_d;      // issue one cycle late
	alu_op_e op_d;         // Opcode matching the unit outputs
	float_t  float_norm;   // Normalized float_result
	word_t   selected;

	// ******************************************************************
	// Alignment with the unit registers
	// ******************************************************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			issue_d <= 1'b0;
			op_d    <= NOP;
		end else begin
			issue_d <= iss.issue;
			op_d    <= iss.op;
		end
	end

	float_normalizer float_normalizer_inst (
		.value      (float_result),
		.normalized (float_norm)
	);

	// Unit pick
	always_comb begin
		case (op_d)
			F_MLT:        selected = float_norm;    // Only op that needs normalizing
			F_NEG, F_ABS: selected = float_result;  // Sign change only
			default:      selected = int_result;    // Zero for unknown codes
		endcase
	end

	// ******************************************************************
	// Output register
	// ******************************************************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result       <= '0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= issue_d;
			if (issue_d)
				result <= selected;  // Held until the next operation
		end
	end

endmodule

// ==== src/alu_top.sv ====
/*
 * ALU top level with a four-phase req/ack host interface.
 * Controller feeds the integer and float units; the result stage merges them.
 */

`timescale 1ns/1ps

module alu_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                req,
	input  alu_op_pkg::alu_op_e op,
	input  alu_op_pkg::word_t   in1,
	input  alu_op_pkg::word_t   in2,
	output logic                ack,
	output alu_op_pkg::word_t   result
);

	import alu_op_pkg::*;
	import float_fmt_pkg::*;

	word_t  int_result;    // Integer unit register
	float_t float_result;  // Float unit register
	logic   result_valid;  // Result stage to controller

	alu_issue_if iss_if ();  // Shared issue bus

	alu_req_ctrl alu_req_ctrl_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.req          (req),
		.op           (op),
		.in1          (in1),
		.in2          (in2),
		.result_valid (result_valid),
		.ack          (ack),
		.iss          (iss_if.ctrl)
	);

	int_unit int_unit_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.iss        (iss_if.unit),
		.int_result (int_result)
	);

	float_unit float_unit_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.iss          (iss_if.unit),
		.float_result (float_result)
	);

	result_select result_select_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.int_result   (int_result),
		.float_result (float_result),
		.iss          (iss_if.unit),
		.result       (result),
		.result_valid (result_valid)
	);

endmodule

// ==== testbench/alu_ref_model.svh ====
/*
 * Reference rules for every ALU operation and an xorshift generator.
 * Included in the testbench module after the package imports.
 */

`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// One 32-bit xorshift step
function automatic logic [31:0] xorshift_next(input logic [31:0] x);
	logic [31:0] s;
	s = x ^ (x << 13);
	s = s ^ (s >> 17);
	s = s ^ (s << 5);
	return s;
endfunction

function automatic logic [31:0] integer_result(input alu_op_e op, input logic [31:0] a,
	input logic [31:0] b);
	logic [63:0] prod;  // Full product, low half kept
	prod = {32'd0, a} * {32'd0, b};
	case (op)
		NOP: return b;
		LOD: return a;
		ADD: return a + b;
		MLT: return prod[31:0];
		NEG: return ~b + 32'd1;
		ABS: return b[31] ? ~b + 32'd1 : b;
		AND: return a & b;
		ORR: return a | b;
		XOR: return a ^ b;
		// Flipping the sign bit turns signed order into unsigned order
		LES: return {31'd0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
		GRE: return {31'd0, (a ^ 32'h8000_0000) > (b ^ 32'h8000_0000)};
		EQU: return {31'd0, a == b};
		SHL: return (b >= 32'd32) ? 32'd0 : a << b[4:0];
		SHR: return (b >= 32'd32) ? 32'd0 : a >> b[4:0];
		SRS: return (b >= 32'd32) ? {32{a[31]}}
			: (a >> b[4:0]) | ({32{a[31]}} & ~(32'hFFFF_FFFF >> b[4:0]));
		default: return 32'd0;  // Float and unknown codes
	endcase
endfunction

// Shift up to the leading one, zero gets the most negative exponent
function automatic float_t normalize_float(input float_t f);
	float_t n;
	n = f;
	if (f.man == 23'd0) begin
		n.exp = 8'h80;
		return n;
	end
	while (!n.man[22]) begin
		n.man = n.man << 1;
		n.exp = n.exp - 8'd1;
	end
	return n;
endfunction

function automatic float_t float_multiply(input float_t x, input float_t y);
	float_t      p;
	int          esum;   // Exact exponent sum
	logic [8:0]  e9;     // Same sum in nine bits
	logic [45:0] mprod;
	esum  = int'($signed(x.exp)) + int'($signed(y.exp)) + 23;
	e9    = esum[8:0];
	mprod = {23'd0, x.man} * {23'd0, y.man};
	p.sign = x.sign ^ y.sign;
	p.exp  = e9[7:0];
	p.man  = (e9[8:7] == 2'b10) ? 23'd0 : mprod[45:23];  // Underflow flush
	return normalize_float(p);
endfunction

function automatic logic [31:0] expected_result(input alu_op_e op, input logic [31:0] a,
	input logic [31:0] b);
	case (op)
		F_MLT: return float_multiply(float_t'(a), float_t'(b));
		F_NEG: return {~b[31], b[30:0]};
		F_ABS: return {1'b0, b[30:0]};
		default: return integer_result(op, a, b);
	endcase
endfunction

`endif

// ==== testbench/alu_tb.sv ====
/*
 * Testbench for the ALU top level: directed corners, then seeded random ops.
 * Concurrent assertions check the req/ack timing and every result.
 */

`timescale 1ns/1ps

module alu_tb;

	import alu_op_pkg::*;
	import float_fmt_pkg::*;

	`include "alu_ref_model.svh"

	localparam int n_directed = 18 * 5 + 5;  // Corner pairs, float corners, unknown codes
	localparam int n_random   = 150;
	localparam int max_cycles = (n_directed + n_random) * 10 + 5 + 100;

	logic    clk = 1'b0;
	logic    rst_n;
	logic    req;
	alu_op_e op;
	word_t   in1;
	word_t   in2;
	logic    ack;
	word_t   result;

	word_t       expected = '0;    // Model value for the op in flight
	logic [31:0] rng = 32'd65165;
	int          value_errors = 0;
	int          protocol_errors = 0;
	int          cycles = 0;
	alu_op_e     kept_ops [18] = '{NOP, LOD, ADD, MLT, F_MLT, NEG, F_NEG, ABS, F_ABS,
		AND, ORR, XOR, LES, GRE, EQU, SHL, SHR, SRS};
	word_t       corner_a [5] = '{32'h0000_0005, 32'h8000_0000, 32'h1234_5678,
		32'hFFFF_FFFF, 32'h0000_0021};
	word_t       corner_b [5] = '{32'hFFFF_FFFD, 32'h7FFF_FFFF, 32'h0000_0004,
		32'h0000_001F, 32'h0000_0021};

	always #2 clk = ~clk;  // 4 ns period

	alu_top alu_top_inst (.clk(clk), .rst_n(rst_n), .req(req), .op(op),
		.in1(in1), .in2(in2), .ack(ack), .result(result));

	// ******************************************************************
	// Checks
	// ******************************************************************

	assert property (@(posedge clk) $rose(rst_n) |-> (!ack && result == '0))
		else begin
			value_errors++;
			$display("mismatch at %0t: ack got %b expected 0, result got %h expected 0",
				$time, $sampled(ack), $sampled(result));
		end

	// Edge 0 is the first one that samples req; ack seen high four samples later
	assert property (@(posedge clk) disable iff (!rst_n)
		$rose(ack) |-> ($past(req, 4) && !$past(req, 5)))
		else begin
			protocol_errors++;
			$display("ack rose at %0t, not three cycles after req was taken", $time);
		end

	assert property (@(posedge clk) disable iff (!rst_n) $past(ack && req) |-> ack)
		else begin
			protocol_errors++;
			$display("ack dropped at %0t while req was still high", $time);
		end

	assert property (@(posedge clk) disable iff (!rst_n) $past(ack && !req) |-> !ack)
		else begin
			protocol_errors++;
			$display("ack still high at %0t after req was released", $time);
		end

	assert property (@(posedge clk) disable iff (!rst_n) $rose(ack) |-> result == expected)
		else begin
			value_errors++;
			$display("mismatch at %0t: result got %h expected %h",
				$time, $sampled(result), $sampled(expected));
		end

	// Held while acked and while the host is idle
	assert property (@(posedge clk) disable iff (!rst_n) (ack || !req) |-> $stable(result))
		else begin
			protocol_errors++;
			$display("result changed at %0t with no operation in flight", $time);
		end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("timeout: handshakes not finished after %0d cycles", max_cycles);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// ******************************************************************
	// Stimulus
	// ******************************************************************

	task automatic next_edge();
		@(posedge clk);
		#1;  // Drive and sample clear of the edge
	endtask

	// One four-phase transfer, req held hold extra cycles after ack
	task automatic run_op(input alu_op_e code, input word_t a, input word_t b, input int hold);
		expected = expected_result(code, a, b);
		op  = code;
		in1 = a;
		in2 = b;
		req = 1'b1;
		do next_edge(); while (!ack);
		repeat (hold) next_edge();  // Back-pressure
		req = 1'b0;
		do next_edge(); while (ack);
	endtask

	initial begin
		alu_op_e code;
		word_t   a;
		word_t   b;
		rst_n = 1'b0;
		req   = 1'b0;
		op    = NOP;
		in1   = '0;
		in2   = '0;
		repeat (5) @(posedge clk);
		#1 rst_n = 1'b1;
		next_edge();
		for (int k = 0; k < 18; k++)
			for (int j = 0; j < 5; j++)
				run_op(kept_ops[k], corner_a[j], corner_b[j], j % 3);
		run_op(F_MLT, 32'h0280_0000, 32'h8140_0000, 0);  // Zero mantissa
		run_op(F_MLT, 32'h4040_0000, 32'h4040_0000, 0);  // Exponent underflow
		run_op(F_MLT, 32'h018F_0000, 32'hFF0F_0000, 1);  // Product with leading zeros
		run_op(alu_op_e'(6'd3), corner_a[0], corner_b[0], 0);
		run_op(alu_op_e'(6'd63), corner_a[3], corner_b[3], 0);
		for (int i = 0; i < n_random; i++) begin
			rng  = xorshift_next(rng);
			a    = rng;
			rng  = xorshift_next(rng);
			b    = rng;
			rng  = xorshift_next(rng);
			code = (rng[5:0] < 6'd54) ? kept_ops[rng[5:0] % 18] : alu_op_e'(rng[11:6]);
			if (code inside {SHL, SHR, SRS})
				b = {26'd0, b[5:0]};  // Mostly in-range shift amounts
			run_op(code, a, b, int'(rng[13:12]));
		end
		repeat (2) next_edge();
		$display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+testbench
src/alu_op_pkg.sv
src/float_fmt_pkg.sv
src/alu_issue_if.sv
src/alu_req_ctrl.sv
src/int_unit.sv
src/float_unit.sv
src/float_normalizer.sv
src/result_select.sv
src/alu_top.sv
testbench/alu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the ALU testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f build.f --top-module alu_tb &&
out=$(./obj_dir/Valu_tb) &&
echo "$out" &&
echo "$out" | grep -q "ALL CHECKS PASSED" &&
echo "simulation passed" && exit 0 ||
{ echo "simulation failed"; exit 1; }
